// File: deskew.f
hdl/deskew_pkg.sv
hdl/skew_counter.sv
hdl/deskew_fsm.sv
hdl/lane_delay_fifo.sv
hdl/deskew_top.sv
tests/deskew_asserts.sv
tests/tb_deskew.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_deskew
FILELIST  := deskew.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_deskew.sv
`timescale 1ns/1ps
`default_nettype none

module tb_deskew;
    import deskew_pkg::*;

    localparam int AM_PERIOD   = 32;
    localparam int N_TRIALS    = 8;
    localparam int STREAM_LEN  = 48;
    // Each phase fits in three marker periods of clocks
    localparam int CYCLE_LIMIT = (N_TRIALS + 5) * 3 * AM_PERIOD + 100;

    localparam int MODE_PASS    = 0;
    localparam int MODE_ALIGN   = 1;
    localparam int MODE_INVALID = 2;

    logic      clock = 1'b0;
    logic      arst_n;
    logic      enable;
    logic      valid;
    logic      am_lock;
    logic      resync;
    lane_bus_t lanes_in;
    lane_bus_t lanes_out;
    logic      deskew_done;
    logic      invalid_skew;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycle  = 0;
    int     src_idx;
    int     gap_pct;
    int     skew [N_LANES];
    string  trial_name;

    deskew_top DUT
    (
        .i_clock        (clock),
        .i_arst_n       (arst_n),
        .i_enable       (enable),
        .i_valid        (valid),
        .i_am_lock      (am_lock),
        .i_resync       (resync),
        .i_lanes        (lanes_in),
        .o_lanes        (lanes_out),
        .o_deskew_done  (deskew_done),
        .o_invalid_skew (invalid_skew)
    );

    always #50 clock = ~clock;

    always @(posedge clock)
    begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Source beat n of a lane, negative beats are idle control blocks
    function automatic lane_word_t make_word(input int n, input int lane);
        lane_word_t w;
        if (n < 0)
        begin
            w.am    = 1'b0;
            w.block = {2'b10, 64'h1e1e_1e1e_1e1e_1e1e};
        end
        else
        begin
            w.am    = ((n % AM_PERIOD) == 0);
            w.block = {2'b01, 8'(lane), 24'(n), 32'(n * 32'h9e37_79b9) ^ 32'(lane)};
        end
        return w;
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("ERR %s: expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_int(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected)
        else
        begin
            errors++;
            $display("ERR %s: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input lane_word_t expected,
                              input lane_word_t actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("ERR %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic pick_skews(input logic overlong);
        int late;
        for (int k = 0; k < N_LANES; k++)
        begin
            skew[k] = $unsigned($random(seed)) % (MAX_SKEW + 1);
        end
        // Lane 0 leads, one other lane trails past the limit
        if (overlong)
        begin
            late       = 1 + ($unsigned($random(seed)) % (N_LANES - 1));
            skew[0]    = 0;
            skew[late] = MAX_SKEW + 1 + ($unsigned($random(seed)) % 8);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clock);
            #1;
            valid  = 1'b0;
            resync = 1'b0;
        end
    endtask

    task automatic pulse_resync();
        @(posedge clock);
        #1;
        resync = 1'b1;
        valid  = 1'b0;
        @(posedge clock);
        #1;
        resync = 1'b0;
        @(negedge clock);
        check_bit("resync done", 1'b0, deskew_done);
        check_bit("resync invalid", 1'b0, invalid_skew);
    endtask

    task automatic run_stream(input string name, input int mode);
        int   max_skew;
        int   trig_idx;
        int   trig_cycle;
        int   shift;
        logic done_seen;
        logic invalid_seen;
        max_skew     = 0;
        trig_cycle   = -100;
        done_seen    = 1'b0;
        invalid_seen = 1'b0;
        for (int k = 0; k < N_LANES; k++)
        begin
            if (skew[k] > max_skew)
            begin
                max_skew = skew[k];
            end
        end
        // Last marker beat, or the beat that pushes the count past the limit
        trig_idx = (mode == MODE_INVALID) ? MAX_SKEW : max_skew;
        src_idx  = 0;
        while (src_idx < STREAM_LEN)
        begin
            @(posedge clock);
            #1;
            valid = ($unsigned($random(seed)) % 100) >= gap_pct;
            for (int k = 0; k < N_LANES; k++)
            begin
                lanes_in[k] = make_word(src_idx - skew[k], k);
            end
            @(negedge clock);
            if (valid && (src_idx == trig_idx))
            begin
                trig_cycle = cycle;
            end
            if (mode == MODE_INVALID)
            begin
                check_bit({name, " done"}, 1'b0, deskew_done);
                if (invalid_skew && !invalid_seen)
                begin
                    check_int({name, " invalid latency"}, 2, cycle - trig_cycle);
                end
                if (invalid_seen)
                begin
                    check_bit({name, " invalid held"}, 1'b1, invalid_skew);
                end
                invalid_seen = invalid_seen | invalid_skew;
            end
            else
            begin
                check_bit({name, " invalid"}, 1'b0, invalid_skew);
                if (mode == MODE_PASS)
                begin
                    check_bit({name, " done"}, 1'b0, deskew_done);
                end
                else if (deskew_done && !done_seen)
                begin
                    done_seen = 1'b1;
                    check_int({name, " done latency"}, 2, cycle - trig_cycle);
                end
                else if (done_seen)
                begin
                    check_bit({name, " done held"}, 1'b1, deskew_done);
                end
                // Undelayed lanes, or every lane at the slowest lane's beat
                if ((mode == MODE_PASS) || done_seen)
                begin
                    for (int k = 0; k < N_LANES; k++)
                    begin
                        shift = (mode == MODE_PASS) ? skew[k] : max_skew;
                        check_word($sformatf("%s lane %0d", name, k),
                                   make_word(src_idx - shift, k), lanes_out[k]);
                    end
                end
            end
            if (valid)
            begin
                src_idx++;
            end
        end
        if (mode == MODE_ALIGN)
        begin
            assert (done_seen)
            else
            begin
                errors++;
                $display("Error in %s: deskew done never rose", name);
            end
        end
        if (mode == MODE_INVALID)
        begin
            assert (invalid_seen)
            else
            begin
                errors++;
                $display("Error in %s: invalid skew was never flagged", name);
            end
        end
    endtask

    initial
    begin
        seed     = 32'h9a4c_d40a;
        arst_n   = 1'b0;
        enable   = 1'b0;
        valid    = 1'b0;
        am_lock  = 1'b0;
        resync   = 1'b0;
        lanes_in = '0;
        src_idx  = 0;
        gap_pct  = 25;
        repeat (5) @(posedge clock);
        #1;
        arst_n = 1'b1;
        enable = 1'b1;

        // Enabled but not yet locked
        pick_skews(1'b0);
        run_stream("pre_lock", MODE_PASS);

        @(posedge clock);
        #1;
        am_lock = 1'b1;
        valid   = 1'b0;
        for (int t = 0; t < N_TRIALS; t++)
        begin
            if (t > 0)
            begin
                pulse_resync();
            end
            if (t < N_TRIALS / 2)
            begin
                gap_pct    = 0;
                trial_name = "align_full";
            end
            else
            begin
                gap_pct    = 25;
                trial_name = "align_gaps";
            end
            idle_cycles(3);
            pick_skews(1'b0);
            run_stream(trial_name, MODE_ALIGN);
        end

        pulse_resync();
        idle_cycles(3);
        pick_skews(1'b1);
        run_stream("invalid_skew", MODE_INVALID);

        pulse_resync();
        idle_cycles(3);
        pick_skews(1'b0);
        run_stream("resync_realign", MODE_ALIGN);

        // Loss of lock clears the delays again
        @(posedge clock);
        #1;
        am_lock = 1'b0;
        valid   = 1'b0;
        idle_cycles(3);
        run_stream("lock_low", MODE_PASS);

        @(posedge clock);
        #1;
        am_lock = 1'b1;
        enable  = 1'b0;
        valid   = 1'b0;
        idle_cycles(3);
        run_stream("enable_low", MODE_PASS);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/deskew_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module deskew_asserts
(
    input logic                           i_clock,
    input logic                           i_arst_n,
    input logic                           i_set_delay,
    input logic                           i_deskew_done,
    input logic                           i_invalid_skew,
    input logic [deskew_pkg::N_LANES-1:0] i_lane_stop
);

    // Aligned and invalid end states only leave through idle
    a_end_state_exclusive : assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        (i_deskew_done || i_invalid_skew) |=>
            !($rose(i_deskew_done) || $rose(i_invalid_skew)))
    else $error("Deskew done and invalid skew followed each other without a resync");

    a_set_delay_single : assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_set_delay |=> !i_set_delay)
    else $error("Set delay pulse lasted more than one cycle");

    // Every lane has seen its marker once aligned
    a_done_all_stopped : assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_deskew_done |-> (&i_lane_stop))
    else $error("Deskew done while a lane counter is still running");

endmodule

bind deskew_fsm deskew_asserts u_deskew_asserts
(
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_set_delay    (o_set_delay),
    .i_deskew_done  (o_deskew_done),
    .i_invalid_skew (o_invalid_skew),
    .i_lane_stop    (o_lane_stop)
);

`default_nettype wire

// File: hdl/deskew_top.sv
`timescale 1ns/1ps
`default_nettype none

module deskew_top
(
    input  logic                  i_clock,
    input  logic                  i_arst_n,
    input  logic                  i_enable,
    input  logic                  i_valid,
    input  logic                  i_am_lock,
    input  logic                  i_resync,
    input  deskew_pkg::lane_bus_t i_lanes,
    output deskew_pkg::lane_bus_t o_lanes,
    output logic                  o_deskew_done,
    output logic                  o_invalid_skew
);
    import deskew_pkg::*;

    logic               count_run;
    logic               clear;
    logic               set_delay;
    logic               common_stop;
    logic [N_LANES-1:0] lane_stop;
    count_t             common_count;
    count_t             lane_count [N_LANES];

    deskew_fsm u_deskew_fsm
    (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_enable       (i_enable),
        .i_valid        (i_valid),
        .i_am_lock      (i_am_lock),
        .i_resync       (i_resync),
        .i_lanes        (i_lanes),
        .i_common_count (common_count),
        .o_count_run    (count_run),
        .o_clear        (clear),
        .o_set_delay    (set_delay),
        .o_common_stop  (common_stop),
        .o_lane_stop    (lane_stop),
        .o_deskew_done  (o_deskew_done),
        .o_invalid_skew (o_invalid_skew)
    );

    // Stops only after every lane, so it ends on the largest skew
    skew_counter u_common_counter
    (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_run    (count_run),
        .i_stop   (common_stop),
        .i_clear  (clear),
        .o_count  (common_count)
    );

    for (genvar k = 0; k < N_LANES; k++)
    begin : g_lane
        skew_counter u_lane_counter
        (
            .i_clock  (i_clock),
            .i_arst_n (i_arst_n),
            .i_valid  (i_valid),
            .i_run    (count_run),
            .i_stop   (lane_stop[k]),
            .i_clear  (clear),
            .o_count  (lane_count[k])
        );

        lane_delay_fifo u_lane_delay
        (
            .i_clock      (i_clock),
            .i_arst_n     (i_arst_n),
            .i_valid      (i_valid),
            .i_set_delay  (set_delay),
            .i_clear      (clear),
            .i_lane_count (lane_count[k]),
            .i_max_count  (common_count),
            .i_word       (i_lanes[k]),
            .o_word       (o_lanes[k])
        );
    end

endmodule

`default_nettype wire

// File: hdl/lane_delay_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lane_delay_fifo
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  logic                   i_valid,
    input  logic                   i_set_delay,
    input  logic                   i_clear,
    input  deskew_pkg::count_t     i_lane_count,
    input  deskew_pkg::count_t     i_max_count,
    input  deskew_pkg::lane_word_t i_word,
    output deskew_pkg::lane_word_t o_word
);
    import deskew_pkg::*;

    lane_word_t        store [MAX_SKEW];
    count_t            delay_q;
    count_t            delay_m1;
    logic [NB_TAP-1:0] tap_sel;

    // Entry k holds the word from k+1 valid beats ago
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            store[0] <= i_word;
            for (int k = 1; k < MAX_SKEW; k++)
            begin
                store[k] <= store[k-1];
            end
        end
    end

    // Lane delay is its distance behind the slowest lane
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            delay_q <= '0;
        end
        else if (i_clear)
        begin
            delay_q <= '0;
        end
        else if (i_set_delay)
        begin
            delay_q <= i_max_count - i_lane_count;
        end
    end

    assign delay_m1 = delay_q - count_t'(1);
    assign tap_sel  = delay_m1[NB_TAP-1:0];

    // Zero delay passes straight through
    assign o_word = (delay_q == '0) ? i_word : store[tap_sel];

endmodule

`default_nettype wire

// File: hdl/deskew_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module deskew_fsm
(
    input  logic                            i_clock,
    input  logic                            i_arst_n,
    input  logic                            i_enable,
    input  logic                            i_valid,
    input  logic                            i_am_lock,
    input  logic                            i_resync,
    input  deskew_pkg::lane_bus_t           i_lanes,
    input  deskew_pkg::count_t              i_common_count,
    output logic                            o_count_run,
    output logic                            o_clear,
    output logic                            o_set_delay,
    output logic                            o_common_stop,
    output logic [deskew_pkg::N_LANES-1:0]  o_lane_stop,
    output logic                            o_deskew_done,
    output logic                            o_invalid_skew
);
    import deskew_pkg::*;

    deskew_state_e      state_q;
    deskew_state_e      state_next;
    logic [N_LANES-1:0] seen_q;
    logic [N_LANES-1:0] am_beat;
    logic               any_am;
    logic               all_seen;
    logic               abort;
    logic               clear_q;

    // Marker flags that belong to a valid beat
    always_comb
    begin
        for (int k = 0; k < N_LANES; k++)
        begin
            am_beat[k] = i_valid && i_lanes[k].am;
        end
    end

    assign any_am   = |am_beat;
    assign abort    = i_resync || !i_am_lock || !i_enable;

    // A lane stops in the very beat its marker shows up
    assign o_lane_stop   = seen_q | am_beat;
    assign all_seen      = &o_lane_stop;
    assign o_common_stop = all_seen;

    // Run already in the first marker beat so trailing lanes count it
    assign o_count_run = (state_q == ST_COUNT) ||
                         ((state_q == ST_WAIT_FIRST) && any_am);

    always_comb
    begin
        state_next = state_q;
        case (state_q)
            ST_IDLE:
            begin
                state_next = ST_WAIT_FIRST;
            end
            ST_WAIT_FIRST:
            begin
                // All lanes may already be aligned
                if (all_seen)
                begin
                    state_next = ST_SET_DELAY;
                end
                else if (any_am)
                begin
                    state_next = ST_COUNT;
                end
            end
            ST_COUNT:
            begin
                // Overrun wins even if the late lane arrives in this beat
                if ((i_common_count > count_t'(MAX_SKEW)) && !(&seen_q))
                begin
                    state_next = ST_INVALID;
                end
                else if (all_seen)
                begin
                    state_next = ST_SET_DELAY;
                end
            end
            ST_SET_DELAY:
            begin
                state_next = ST_ALIGNED;
            end
            ST_ALIGNED, ST_INVALID:
            begin
                state_next = state_q;
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase

        if (abort)
        begin
            state_next = ST_IDLE;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q <= ST_IDLE;
            seen_q  <= '0;
            clear_q <= 1'b0;
        end
        else
        begin
            state_q <= state_next;
            // One cycle clear on every entry to idle
            clear_q <= (state_next == ST_IDLE) && (state_q != ST_IDLE);
            if (state_q == ST_IDLE)
            begin
                seen_q <= '0;
            end
            else if (o_count_run)
            begin
                seen_q <= o_lane_stop;
            end
        end
    end

    assign o_clear        = clear_q;
    assign o_set_delay    = (state_q == ST_SET_DELAY);
    assign o_deskew_done  = (state_q == ST_ALIGNED);
    assign o_invalid_skew = (state_q == ST_INVALID);

endmodule

`default_nettype wire

// File: hdl/skew_counter.sv
`timescale 1ns/1ps
`default_nettype none

module skew_counter
(
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  logic               i_valid,
    input  logic               i_run,
    input  logic               i_stop,
    input  logic               i_clear,
    output deskew_pkg::count_t o_count
);
    import deskew_pkg::*;

    count_t count_q;
    logic   advance;

    // Holds at all ones so a long skew never wraps below the limit
    assign advance = i_valid && i_run && !i_stop && (count_q != '1);

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            count_q <= '0;
        end
        else if (i_clear)
        begin
            count_q <= '0;
        end
        else if (advance)
        begin
            count_q <= count_q + count_t'(1);
        end
    end

    assign o_count = count_q;

endmodule

`default_nettype wire

// File: hdl/deskew_pkg.sv
`default_nettype none

package deskew_pkg;

    // Lane geometry
    localparam int N_LANES  = 4;
    localparam int NB_BLOCK = 66;

    // Largest lane to lane skew in valid beats, also the delay line depth
    localparam int MAX_SKEW = 16;

    // Counts must reach MAX_SKEW+1 so an overlong skew is still visible
    localparam int NB_DELAY = $clog2(MAX_SKEW + 2);
    localparam int NB_TAP   = $clog2(MAX_SKEW);

    typedef logic [NB_DELAY-1:0] count_t;

    // One coded block plus its alignment marker flag
    typedef struct packed {
        logic                am;
        logic [NB_BLOCK-1:0] block;
    } lane_word_t;

    typedef lane_word_t [N_LANES-1:0] lane_bus_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_FIRST,
        ST_COUNT,
        ST_SET_DELAY,
        ST_ALIGNED,
        ST_INVALID
    } deskew_state_e;

endpackage

`default_nettype wire
